/* sram_axi_pkg.sv */
`default_nettype none

package sram_axi_pkg;

    // Bus widths
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;
    localparam int id_w   = 4;
    localparam int addr_w = 32;
    localparam int len_w  = 8;

    // Address field of the macro request, wide enough for the largest depth
    localparam int sram_addr_w = 16;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // Shared by AW and AR
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
        logic [1:0]        burst;
    } axi_ax_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        axi_resp_e       resp;
    } axi_b_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } axi_r_t;

    // One access to the macro per cycle
    typedef struct packed {
        logic                   cs;
        logic                   oe;
        logic [sram_addr_w-1:0] addr;
        logic [strb_w-1:0]      web;
        logic [data_w-1:0]      wdata;
    } sram_req_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2,
        WRESP = 2'd3
    } sram_state_e;

endpackage

`default_nettype wire

/* sram_macro.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_macro #(
    parameter int mem_addr_bits = 14
) (
    input  logic                            clk,
    input  sram_axi_pkg::sram_req_t         req,
    output logic [sram_axi_pkg::data_w-1:0] rdata
);
    import sram_axi_pkg::*;

    localparam int depth = 2 ** mem_addr_bits;

    logic [mem_addr_bits-1:0] word_idx;
    logic                     rd_en;

    // Only the low bits of the request address select a word
    assign word_idx = req.addr[mem_addr_bits-1:0];
    assign rd_en    = req.cs & req.oe;

    // Each byte lane is its own array, like the lanes of a vendor macro
    for (genvar lane = 0; lane < strb_w; lane++) begin : g_lane
        logic [7:0] lane_mem [depth];
        logic [7:0] lane_q;
        logic       lane_we;

        // web is active low
        assign lane_we = req.cs & ~req.web[lane];

        always_ff @(posedge clk) begin
            if (lane_we) begin
                lane_mem[word_idx] <= req.wdata[lane*8 +: 8];
            end
        end

        // Registered read, held while the macro is not selected
        always_ff @(posedge clk) begin
            if (rd_en) begin
                lane_q <= lane_mem[word_idx];
            end
        end

        assign rdata[lane*8 +: 8] = lane_q;
    end

endmodule

`default_nettype wire

/* sram_axi_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_axi_ctrl #(
    parameter int mem_addr_bits = 14
) (
    input  logic                            clk,
    input  logic                            rstn,

    input  sram_axi_pkg::axi_ax_t           aw,
    input  logic                            aw_valid,
    output logic                            aw_ready,

    input  sram_axi_pkg::axi_w_t            w,
    input  logic                            w_valid,
    output logic                            w_ready,

    output sram_axi_pkg::axi_b_t            b,
    output logic                            b_valid,
    input  logic                            b_ready,

    input  sram_axi_pkg::axi_ax_t           ar,
    input  logic                            ar_valid,
    output logic                            ar_ready,

    output sram_axi_pkg::axi_r_t            r,
    output logic                            r_valid,
    input  logic                            r_ready,

    output sram_axi_pkg::sram_req_t         req,
    input  logic [sram_axi_pkg::data_w-1:0] rdata
);
    import sram_axi_pkg::*;

    sram_state_e state_q;
    sram_state_e state_d;

    logic [len_w-1:0] beat_cnt_q;
    logic [len_w-1:0] beat_cnt_d;

    // Read data sits in the macro output register
    logic r_valid_q;
    logic r_valid_d;

    // Stored on address acceptance
    logic [id_w-1:0]          id_q;
    logic [mem_addr_bits-1:0] base_q;
    logic [len_w-1:0]         len_q;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;

    logic [mem_addr_bits-1:0] beat_addr;
    logic                     last_beat;
    logic                     rd_issue;

    // Handshakes
    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign b_hs  = b_valid & b_ready;
    assign ar_hs = ar_valid & ar_ready;
    assign r_hs  = r_valid & r_ready;

    // Write wins when both address channels are valid
    assign aw_ready = (state_q == IDLE);
    assign ar_ready = (state_q == IDLE) & ~aw_valid;
    assign w_ready  = (state_q == WRITE);
    assign b_valid  = (state_q == WRESP);
    assign r_valid  = r_valid_q;

    // Incrementing burst, wraps at the memory depth
    assign beat_addr = base_q + mem_addr_bits'(beat_cnt_q);
    assign last_beat = (beat_cnt_q == len_q);

    // Read of the current beat goes out while no data is waiting
    assign rd_issue = (state_q == READ) & ~r_valid_q;

    always_comb begin
        state_d    = state_q;
        beat_cnt_d = beat_cnt_q;
        r_valid_d  = r_valid_q;

        case (state_q)
            IDLE: begin
                if (aw_hs) begin
                    state_d    = WRITE;
                    beat_cnt_d = '0;
                end else if (ar_hs) begin
                    state_d    = READ;
                    beat_cnt_d = '0;
                end
            end

            WRITE: begin
                if (w_hs) begin
                    beat_cnt_d = beat_cnt_q + 1'b1;
                    if (w.last) begin
                        state_d = WRESP;
                    end
                end
            end

            WRESP: begin
                if (b_hs) begin
                    state_d = IDLE;
                end
            end

            READ: begin
                if (rd_issue) begin
                    r_valid_d = 1'b1;
                end else if (r_hs) begin
                    r_valid_d = 1'b0;
                    if (last_beat) begin
                        state_d = IDLE;
                    end else begin
                        beat_cnt_d = beat_cnt_q + 1'b1;
                    end
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Macro request, idle unless a write beat or a read issue is in this cycle
    always_comb begin
        req       = '0;
        req.web   = '1;
        req.addr  = sram_addr_w'(beat_addr);
        req.wdata = w.data;

        if (w_hs) begin
            req.cs  = 1'b1;
            req.web = ~w.strb;
        end else if (rd_issue) begin
            req.cs = 1'b1;
            req.oe = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q    <= IDLE;
            beat_cnt_q <= '0;
            r_valid_q  <= 1'b0;
        end else begin
            state_q    <= state_d;
            beat_cnt_q <= beat_cnt_d;
            r_valid_q  <= r_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            id_q   <= aw.id;
            base_q <= aw.addr[mem_addr_bits+1:2];
            len_q  <= aw.len;
        end else if (ar_hs) begin
            id_q   <= ar.id;
            base_q <= ar.addr[mem_addr_bits+1:2];
            len_q  <= ar.len;
        end
    end

    // Responses echo the stored ID, always OKAY
    assign b = '{id: id_q, resp: OKAY};

    assign r = '{
        id:   id_q,
        data: rdata,
        resp: OKAY,
        last: last_beat
    };

endmodule

`default_nettype wire

/* sram_axi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_axi_top #(
    parameter int mem_addr_bits = 14
) (
    input  logic                  clk,
    input  logic                  rstn,

    input  sram_axi_pkg::axi_ax_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,

    input  sram_axi_pkg::axi_w_t  w,
    input  logic                  w_valid,
    output logic                  w_ready,

    output sram_axi_pkg::axi_b_t  b,
    output logic                  b_valid,
    input  logic                  b_ready,

    input  sram_axi_pkg::axi_ax_t ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,

    output sram_axi_pkg::axi_r_t  r,
    output logic                  r_valid,
    input  logic                  r_ready
);
    import sram_axi_pkg::*;

    sram_req_t         req;
    logic [data_w-1:0] rdata;

    sram_axi_ctrl #(
        .mem_addr_bits(mem_addr_bits)
    ) sram_axi_ctrl_inst (
        .clk     (clk),
        .rstn    (rstn),
        .aw      (aw),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .w       (w),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .b       (b),
        .b_valid (b_valid),
        .b_ready (b_ready),
        .ar      (ar),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .r       (r),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .req     (req),
        .rdata   (rdata)
    );

    sram_macro #(
        .mem_addr_bits(mem_addr_bits)
    ) sram_macro_inst (
        .clk  (clk),
        .req  (req),
        .rdata(rdata)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rstn
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held for 8 cycles, released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end
endmodule

`default_nettype wire

/* sram_axi_tb_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_axi_tb_assert (
    input logic                 clk,
    input logic                 rstn,
    input logic                 aw_valid,
    input logic                 aw_ready,
    input logic                 ar_valid,
    input logic                 ar_ready,
    input sram_axi_pkg::axi_b_t b,
    input logic                 b_valid,
    input logic                 b_ready,
    input sram_axi_pkg::axi_r_t r,
    input logic                 r_valid,
    input logic                 r_ready
);
    logic addr_seen;

    // Set once the first address has been accepted after reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_seen <= 1'b0;
        end else if ((aw_valid && aw_ready) || (ar_valid && ar_ready)) begin
            addr_seen <= 1'b1;
        end
    end

    r_hold: assert property (@(posedge clk) disable iff (!rstn)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("R channel changed before r_ready");

    b_hold: assert property (@(posedge clk) disable iff (!rstn)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("B channel changed before b_ready");

    rb_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(r_valid && b_valid))
        else $error("r_valid and b_valid high together");

    no_early_resp: assert property (@(posedge clk) disable iff (!rstn)
        !addr_seen |-> !r_valid && !b_valid)
        else $error("Response before any address was accepted");
endmodule

bind sram_axi_ctrl sram_axi_tb_assert sram_axi_tb_assert_inst (
    .clk     (clk),
    .rstn    (rstn),
    .aw_valid(aw_valid),
    .aw_ready(aw_ready),
    .ar_valid(ar_valid),
    .ar_ready(ar_ready),
    .b       (b),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .r       (r),
    .r_valid (r_valid),
    .r_ready (r_ready)
);

`default_nettype wire

/* sram_axi_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_axi_tb;
    import sram_axi_pkg::*;

    localparam int mem_addr_bits = 14;
    localparam int depth = 2 ** mem_addr_bits;
    localparam int max_wait = 100;

    logic clk;
    logic rstn;
    axi_ax_t aw;
    logic aw_valid;
    logic aw_ready;
    axi_w_t w;
    logic w_valid;
    logic w_ready;
    axi_b_t b;
    logic b_valid;
    logic b_ready;
    axi_ax_t ar;
    logic ar_valid;
    logic ar_ready;
    axi_r_t r;
    logic r_valid;
    logic r_ready;

    logic [31:0] ref_mem [depth];
    logic [31:0] rng_state;
    logic [31:0] beat_data [$];
    logic [3:0] beat_strb [$];

    tb_clock_gen tb_clock_gen_inst (.clk(clk), .rstn(rstn));

    sram_axi_top #(.mem_addr_bits(mem_addr_bits)) sram_axi_top_inst (
        .clk(clk), .rstn(rstn),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Word index of beat n modulo the memory depth
    function automatic int word_index(input logic [31:0] addr, input int beat);
        return int'(((addr >> 2) + 32'(beat)) % 32'(depth));
    endfunction

    function automatic void ref_write(input int idx, input logic [31:0] data,
                                      input logic [3:0] strb);
        int lane;
        for (lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                ref_mem[idx][lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, max_wait);
        abort_run();
    endtask

    task automatic check_b(input string name, input axi_b_t exp, input axi_b_t got);
        if (got !== exp) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_r(input string name, input axi_r_t exp, input axi_r_t got);
        if (got !== exp) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, got);
            abort_run();
        end
    endtask

    // Channel tasks start and end on a falling edge
    task automatic send_aw(input axi_ax_t ax);
        int cyc;
        aw = ax;
        aw_valid = 1'b1;
        cyc = 0;
        #1;
        if (ar_ready) begin
            $display("Error: ar_ready is high while aw_valid is high");
            abort_run();
        end
        while (!aw_ready) begin
            if (cyc >= max_wait) report_timeout("AW handshake");
            @(negedge clk);
            #1;
            cyc++;
        end
        @(negedge clk);
        aw_valid = 1'b0;
    endtask

    task automatic send_ar(input axi_ax_t ax);
        int cyc;
        ar = ax;
        ar_valid = 1'b1;
        cyc = 0;
        #1;
        while (!ar_ready) begin
            if (cyc >= max_wait) report_timeout("AR handshake");
            @(negedge clk);
            #1;
            cyc++;
        end
        @(negedge clk);
        ar_valid = 1'b0;
    endtask

    task automatic send_w(input axi_w_t wb);
        int cyc;
        w = wb;
        w_valid = 1'b1;
        cyc = 0;
        #1;
        while (!w_ready) begin
            if (cyc >= max_wait) report_timeout("W handshake");
            @(negedge clk);
            #1;
            cyc++;
        end
        @(negedge clk);
        w_valid = 1'b0;
    endtask

    task automatic recv_b(input int stall, output axi_b_t got);
        int cyc;
        cyc = 0;
        #1;
        while (!b_valid) begin
            if (cyc >= max_wait) report_timeout("write response");
            @(negedge clk);
            #1;
            cyc++;
        end
        @(negedge clk);
        repeat (stall) @(negedge clk);
        b_ready = 1'b1;
        #1;
        got = b;
        @(negedge clk);
        b_ready = 1'b0;
    endtask

    task automatic recv_r(input int stall, output axi_r_t got);
        int cyc;
        cyc = 0;
        #1;
        while (!r_valid) begin
            if (cyc >= max_wait) report_timeout("read data beat");
            @(negedge clk);
            #1;
            cyc++;
        end
        @(negedge clk);
        repeat (stall) @(negedge clk);
        r_ready = 1'b1;
        #1;
        got = r;
        @(negedge clk);
        r_ready = 1'b0;
    endtask

    task automatic clear_beats();
        beat_data.delete();
        beat_strb.delete();
    endtask

    task automatic add_beat(input logic [31:0] data, input logic [3:0] strb);
        beat_data.push_back(data);
        beat_strb.push_back(strb);
    endtask

    task automatic write_burst(input string name, input logic [3:0] tid,
                               input logic [31:0] addr, input int b_stall);
        axi_ax_t ax;
        axi_w_t wb;
        axi_b_t got;
        axi_b_t exp;
        int n;
        int i;
        n = beat_data.size();
        ax = '{id: tid, addr: addr, len: len_w'(n - 1), burst: 2'b01};
        send_aw(ax);
        for (i = 0; i < n; i++) begin
            wb = '{data: beat_data[i], strb: beat_strb[i], last: (i == n - 1)};
            send_w(wb);
            ref_write(word_index(addr, i), beat_data[i], beat_strb[i]);
        end
        recv_b(b_stall, got);
        exp = '{id: tid, resp: OKAY};
        check_b(name, exp, got);
    endtask

    // Random stall of 0 to stall_max cycles before each beat is taken
    task automatic read_burst(input string name, input logic [3:0] tid,
                              input logic [31:0] addr, input int len, input int stall_max);
        axi_ax_t ax;
        axi_r_t got;
        axi_r_t exp;
        int stall;
        int i;
        ax = '{id: tid, addr: addr, len: len_w'(len), burst: 2'b01};
        send_ar(ax);
        for (i = 0; i <= len; i++) begin
            stall = int'(next_rand() % 32'(stall_max + 1));
            recv_r(stall, got);
            exp = '{id: tid, data: ref_mem[word_index(addr, i)], resp: OKAY,
                    last: (i == len)};
            check_r(name, exp, got);
        end
    endtask

    task automatic test_single();
        clear_beats();
        add_beat(next_rand(), 4'hf);
        write_burst("single", 4'h3, 32'h0000_0100, 0);
        read_burst("single", 4'h5, 32'h0000_0100, 0, 0);
    endtask

    task automatic test_burst8();
        int i;
        clear_beats();
        for (i = 0; i < 8; i++) begin
            add_beat(next_rand(), 4'hf);
        end
        write_burst("burst8", 4'h7, 32'h0000_0200, 0);
        read_burst("burst8", 4'h9, 32'h0000_0200, 7, 0);
    endtask

    task automatic test_strobes();
        clear_beats();
        add_beat(32'h1122_3344, 4'hf);
        add_beat(32'hdead_beef, 4'hf);
        write_burst("strobe_full", 4'h1, 32'h0000_0300, 0);
        clear_beats();
        add_beat(32'haabb_ccdd, 4'b0010);
        write_burst("strobe_byte", 4'h2, 32'h0000_0300, 0);
        clear_beats();
        add_beat(32'h5566_7788, 4'b1100);
        add_beat(32'h99aa_bbcc, 4'b0001);
        write_burst("strobe_half", 4'h3, 32'h0000_0300, 0);
        read_burst("strobes", 4'h4, 32'h0000_0300, 1, 0);
    endtask

    task automatic test_backpressure();
        int i;
        clear_beats();
        for (i = 0; i < 6; i++) begin
            add_beat(next_rand(), 4'hf);
        end
        write_burst("backpressure", 4'ha, 32'h0000_0400, int'(next_rand() % 32'd7));
        read_burst("backpressure", 4'hb, 32'h0000_0400, 5, 6);
    endtask

    // AW and AR valid in the same cycle so the write goes first
    task automatic test_same_cycle();
        axi_ax_t ax_w;
        axi_w_t wb;
        axi_b_t got;
        axi_b_t exp;
        logic [31:0] data;
        clear_beats();
        add_beat(32'h0bad_f00d, 4'hf);
        write_burst("same_cycle_pre", 4'h1, 32'h0000_0500, 0);
        data = next_rand();
        ax_w = '{id: 4'h2, addr: 32'h0000_0500, len: '0, burst: 2'b01};
        ar = '{id: 4'h6, addr: 32'h0000_0500, len: '0, burst: 2'b01};
        ar_valid = 1'b1;
        send_aw(ax_w);
        wb = '{data: data, strb: 4'hf, last: 1'b1};
        send_w(wb);
        ref_write(word_index(32'h0000_0500, 0), data, 4'hf);
        recv_b(0, got);
        exp = '{id: 4'h2, resp: OKAY};
        check_b("same_cycle", exp, got);
        read_burst("same_cycle", 4'h6, 32'h0000_0500, 0, 0);
    endtask

    task automatic test_wrap();
        clear_beats();
        add_beat(next_rand(), 4'hf);
        write_burst("wrap", 4'hc, 32'((5 + depth) * 4), 0);
        read_burst("wrap", 4'hd, 32'h0000_0014, 0, 0);
    endtask

    initial begin
        int cyc;
        rng_state = 32'd79035;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        ar = '0;
        ar_valid = 1'b0;
        r_ready = 1'b0;
        cyc = 0;
        while (rstn !== 1'b1) begin
            if (cyc >= max_wait) report_timeout("reset release");
            @(negedge clk);
            cyc++;
        end
        @(negedge clk);
        test_single();
        test_burst8();
        test_strobes();
        test_backpressure();
        test_same_cycle();
        test_wrap();
        $display("all tests passed");
        $finish;
    end
endmodule

`default_nettype wire

/* all.f */
sram_axi_pkg.sv
sram_macro.sv
sram_axi_ctrl.sv
sram_axi_top.sv
tb_clock_gen.sv
sram_axi_tb_assert.sv
sram_axi_tb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module sram_axi_tb -f all.f

run: compile
	@out=$$(./obj_dir/Vsram_axi_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^all tests passed$$"

clean:
	rm -rf obj_dir
